// ==== rtl/wc_pkg.sv ====
// shared definitions for the CPU core: memory map, command queue sizes, address views
package wc_pkg;

    // CPU bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int ofs_w  = 11;
    localparam int page_w = 5;

    // 2 KB pages in the CPU map
    localparam logic [page_w-1:0] page_shram = 5'h19;
    localparam logic [page_w-1:0] page_fix   = 5'h1A;
    localparam logic [page_w-1:0] page_scr   = 5'h1B;
    localparam logic [page_w-1:0] page_obj   = 5'h1C;
    localparam logic [page_w-1:0] page_pal   = 5'h1D;

    // RAM region indexes
    localparam int region_w = 3;
    localparam logic [region_w-1:0] region_shram = 3'd0;
    localparam logic [region_w-1:0] region_fix   = 3'd1;
    localparam logic [region_w-1:0] region_scr   = 3'd2;
    localparam logic [region_w-1:0] region_obj   = 3'd3;
    localparam logic [region_w-1:0] region_pal   = 3'd4;
    localparam int region_count = 5;

    // scroll registers, main CPU only
    localparam logic [addr_w-1:0] scrx_lo_addr = 16'hF800;
    localparam logic [addr_w-1:0] scrx_hi_addr = 16'hF801;
    localparam logic [addr_w-1:0] scry_addr    = 16'hF802;

    localparam logic [data_w-1:0] open_bus = 8'hFF;

    // sound command queue, the consumer latch holds one more entry
    localparam int cmd_depth = 4;
    localparam int cmd_cnt_w = 3;
    localparam logic [cmd_cnt_w-1:0] cmd_credits = cmd_cnt_w'(cmd_depth + 1);

    // CPU address as a raw word or as page plus offset
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [page_w-1:0] page;
            logic [ofs_w-1:0]  ofs;
        } map;
    } cpu_addr_u;

endpackage

// ==== rtl/wc_shared_arb.sv ====
// shared RAM arbiter: round-robin grant, wait states, region decode and scroll registers
`timescale 1ns/1ps

module wc_shared_arb
    import wc_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                main_cs,
    input  logic                main_wr_n,
    input  logic [addr_w-1:0]   main_addr,
    input  logic [data_w-1:0]   main_wdata,
    input  logic                sub_cs,
    input  logic                sub_wr_n,
    input  logic [addr_w-1:0]   sub_addr,
    input  logic [data_w-1:0]   sub_wdata,
    output logic                main_wait,
    output logic                sub_wait,
    output logic                ram_en,
    output logic                ram_we,
    output logic [region_w-1:0] ram_region,
    output logic [ofs_w-1:0]    ram_ofs,
    output logic [data_w-1:0]   ram_wdata,
    output logic                rd_open,
    output logic                main_done,
    output logic                sub_done,
    output logic [8:0]          scrx,
    output logic [data_w-1:0]   scry
);

    logic                main_gnt;
    logic                sub_gnt;
    logic                any_gnt;
    logic                last_sub;
    logic                mapped;
    logic                gnt_wr_n;
    logic [data_w-1:0]   gnt_wdata;
    logic [region_w-1:0] region;
    cpu_addr_u           gnt_addr;

    // a request stays open until its done cycle
    assign main_wait = main_cs & ~main_done;
    assign sub_wait  = sub_cs & ~sub_done;

    // on a tie the master not served last wins
    assign main_gnt = main_wait & (~sub_wait | last_sub);
    assign sub_gnt  = sub_wait & ~main_gnt;
    assign any_gnt  = main_gnt | sub_gnt;

    always_comb begin
        gnt_addr.raw = sub_gnt ? sub_addr : main_addr;
        gnt_wr_n     = sub_gnt ? sub_wr_n : main_wr_n;
        gnt_wdata    = sub_gnt ? sub_wdata : main_wdata;
    end

    // page to region
    always_comb begin
        region = region_shram;
        mapped = 1'b1;
        case (gnt_addr.map.page)
            page_shram: region = region_shram;
            page_fix:   region = region_fix;
            page_scr:   region = region_scr;
            page_obj:   region = region_obj;
            page_pal:   region = region_pal;
            default:    mapped = 1'b0;
        endcase
    end

    assign ram_en     = any_gnt & mapped;
    assign ram_we     = ram_en & ~gnt_wr_n;
    assign ram_region = region;
    assign ram_ofs    = gnt_addr.map.ofs;
    assign ram_wdata  = gnt_wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_done <= 1'b0;
            sub_done  <= 1'b0;
            last_sub  <= 1'b1;
            rd_open   <= 1'b0;
        end else begin
            main_done <= main_gnt;
            sub_done  <= sub_gnt;
            if (any_gnt) begin
                last_sub <= sub_gnt;
            end
            // completing read of an unmapped address
            rd_open <= any_gnt & ~mapped & gnt_wr_n;
        end
    end

    // scroll latches see main writes only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scrx <= '0;
            scry <= '0;
        end else if (main_gnt && !gnt_wr_n) begin
            case (gnt_addr.raw)
                scrx_lo_addr: scrx[7:0] <= gnt_wdata;
                scrx_hi_addr: scrx[8]   <= gnt_wdata[0];
                scry_addr:    scry      <= gnt_wdata;
                default:      ;
            endcase
        end
    end

endmodule

// ==== rtl/wc_shared_ram.sv ====
// banked work and video RAM shared by both CPUs, registered read port
`timescale 1ns/1ps

module wc_shared_ram
    import wc_pkg::*;
(
    input  logic                clk,
    input  logic                ram_en,
    input  logic                ram_we,
    input  logic [region_w-1:0] ram_region,
    input  logic [ofs_w-1:0]    ram_ofs,
    input  logic [data_w-1:0]   ram_wdata,
    input  logic                rd_open,
    output logic [data_w-1:0]   rdata
);

    // one 2 KB bank per region
    logic [data_w-1:0] mem [region_count][2**ofs_w];
    logic [data_w-1:0] rd_q;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_region][ram_ofs] <= ram_wdata;
        end
        if (ram_en) begin
            rd_q <= mem[ram_region][ram_ofs];
        end
    end

    // only one master completes per cycle so both share this
    assign rdata = rd_open ? open_bus : rd_q;

endmodule

// ==== rtl/wc_cmd_producer.sv ====
// main-side sound command writer with credit count and CPU stall
`timescale 1ns/1ps

module wc_cmd_producer
    import wc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_wr,
    input  logic [data_w-1:0] cmd_data,
    input  logic              credit_ret,
    output logic              cmd_wait,
    output logic              push,
    output logic [data_w-1:0] push_data
);

    logic [cmd_cnt_w-1:0] credit;
    logic                 has_credit;

    assign has_credit = (credit != '0);

    // stall the main CPU until a slot frees up
    assign cmd_wait  = cmd_wr & ~has_credit;
    assign push      = cmd_wr & has_credit;
    assign push_data = cmd_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit <= cmd_credits;
        end else begin
            case ({push, credit_ret})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/wc_cmd_fifo.sv ====
// sound command queue, circular buffer between producer and consumer
`timescale 1ns/1ps

module wc_cmd_fifo
    import wc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  logic [data_w-1:0] push_data,
    input  logic              pop,
    output logic              empty,
    output logic [data_w-1:0] pop_data
);

    logic [data_w-1:0]            mem [cmd_depth];
    logic [$clog2(cmd_depth)-1:0] wr_ptr;
    logic [$clog2(cmd_depth)-1:0] rd_ptr;
    logic [cmd_cnt_w-1:0]         count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

endmodule

// ==== rtl/wc_cmd_consumer.sv ====
// sound-side command latch with pending flag and credit return
`timescale 1ns/1ps

module wc_cmd_consumer
    import wc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              empty,
    input  logic [data_w-1:0] pop_data,
    input  logic              snd_ack,
    output logic              pop,
    output logic [data_w-1:0] snd_cmd,
    output logic              snd_pending,
    output logic              credit_ret
);

    // refill as soon as the latch is free
    assign pop = ~snd_pending & ~empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_cmd     <= '0;
            snd_pending <= 1'b0;
            credit_ret  <= 1'b0;
        end else begin
            // one credit back per acknowledged command
            credit_ret <= snd_ack & snd_pending;
            if (pop) begin
                snd_cmd     <= pop_data;
                snd_pending <= 1'b1;
            end else if (snd_ack) begin
                snd_pending <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/wc_game_core.sv ====
// CPU-side core: shared RAM arbitration and the main to sound command path
`timescale 1ns/1ps

module wc_game_core
    import wc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // main CPU bus
    input  logic              main_cs,
    input  logic              main_wr_n,
    input  logic [addr_w-1:0] main_addr,
    input  logic [data_w-1:0] main_wdata,
    output logic [data_w-1:0] main_rdata,
    output logic              main_wait_req,
    // sub CPU bus
    input  logic              sub_cs,
    input  logic              sub_wr_n,
    input  logic [addr_w-1:0] sub_addr,
    input  logic [data_w-1:0] sub_wdata,
    output logic [data_w-1:0] sub_rdata,
    output logic              sub_wait_req,
    // sound commands
    input  logic              cmd_wr,
    input  logic [data_w-1:0] cmd_data,
    output logic              cmd_wait,
    output logic [data_w-1:0] snd_cmd,
    output logic              snd_pending,
    input  logic              snd_ack,
    // video scroll
    output logic [8:0]        scrx,
    output logic [data_w-1:0] scry
);

    logic                ram_en;
    logic                ram_we;
    logic [region_w-1:0] ram_region;
    logic [ofs_w-1:0]    ram_ofs;
    logic [data_w-1:0]   ram_wdata;
    logic [data_w-1:0]   ram_rdata;
    logic                rd_open;
    logic                main_done;
    logic                sub_done;
    logic                push;
    logic [data_w-1:0]   push_data;
    logic                pop;
    logic [data_w-1:0]   pop_data;
    logic                empty;
    logic                credit_ret;

    // data reaches a master only in its completion cycle
    assign main_rdata = main_done ? ram_rdata : open_bus;
    assign sub_rdata  = sub_done ? ram_rdata : open_bus;

    wc_shared_arb wc_shared_arb_inst (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .main_cs    ( main_cs       ),
        .main_wr_n  ( main_wr_n     ),
        .main_addr  ( main_addr     ),
        .main_wdata ( main_wdata    ),
        .sub_cs     ( sub_cs        ),
        .sub_wr_n   ( sub_wr_n      ),
        .sub_addr   ( sub_addr      ),
        .sub_wdata  ( sub_wdata     ),
        .main_wait  ( main_wait_req ),
        .sub_wait   ( sub_wait_req  ),
        .ram_en     ( ram_en        ),
        .ram_we     ( ram_we        ),
        .ram_region ( ram_region    ),
        .ram_ofs    ( ram_ofs       ),
        .ram_wdata  ( ram_wdata     ),
        .rd_open    ( rd_open       ),
        .main_done  ( main_done     ),
        .sub_done   ( sub_done      ),
        .scrx       ( scrx          ),
        .scry       ( scry          )
    );

    wc_shared_ram wc_shared_ram_inst (
        .clk        ( clk           ),
        .ram_en     ( ram_en        ),
        .ram_we     ( ram_we        ),
        .ram_region ( ram_region    ),
        .ram_ofs    ( ram_ofs       ),
        .ram_wdata  ( ram_wdata     ),
        .rd_open    ( rd_open       ),
        .rdata      ( ram_rdata     )
    );

    wc_cmd_producer wc_cmd_producer_inst (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cmd_wr     ( cmd_wr        ),
        .cmd_data   ( cmd_data      ),
        .credit_ret ( credit_ret    ),
        .cmd_wait   ( cmd_wait      ),
        .push       ( push          ),
        .push_data  ( push_data     )
    );

    wc_cmd_fifo wc_cmd_fifo_inst (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .push       ( push          ),
        .push_data  ( push_data     ),
        .pop        ( pop           ),
        .empty      ( empty         ),
        .pop_data   ( pop_data      )
    );

    wc_cmd_consumer wc_cmd_consumer_inst (
        .clk         ( clk          ),
        .arst_n      ( arst_n       ),
        .empty       ( empty        ),
        .pop_data    ( pop_data     ),
        .snd_ack     ( snd_ack      ),
        .pop         ( pop          ),
        .snd_cmd     ( snd_cmd      ),
        .snd_pending ( snd_pending  ),
        .credit_ret  ( credit_ret   )
    );

endmodule

// ==== sim/tb_wc_game_core.sv ====
// directed testbench for the CPU core: two bus masters, a RAM reference model and sound commands
`timescale 1ns/1ps

module tb_wc_game_core
    import wc_pkg::*;
();

    localparam int clk_period    = 8;
    // settle point inside the low phase, for combinational stall outputs
    localparam int settle_ns     = 2;
    localparam int credits_total = cmd_depth + 1;
    // the tests need roughly 200 cycles, the limit leaves wide margin
    localparam int timeout_cycles = 2000;

    logic              clk;
    logic              arst_n;
    logic              main_cs;
    logic              main_wr_n;
    logic [addr_w-1:0] main_addr;
    logic [data_w-1:0] main_wdata;
    logic [data_w-1:0] main_rdata;
    logic              main_wait_req;
    logic              sub_cs;
    logic              sub_wr_n;
    logic [addr_w-1:0] sub_addr;
    logic [data_w-1:0] sub_wdata;
    logic [data_w-1:0] sub_rdata;
    logic              sub_wait_req;
    logic              cmd_wr;
    logic [data_w-1:0] cmd_data;
    logic              cmd_wait;
    logic [data_w-1:0] snd_cmd;
    logic              snd_pending;
    logic              snd_ack;
    logic [8:0]        scrx;
    logic [data_w-1:0] scry;

    integer            seed = 32'h912d1733;
    int                cycle_count = 0;
    string             test_name;
    bit                last_main;
    logic [data_w-1:0] ref_mem [region_count][2**ofs_w];
    logic [page_w-1:0] region_pages [region_count];
    logic [8:0]        exp_scrx;
    logic [data_w-1:0] exp_scry;
    logic [addr_w-1:0] written [$];

    wc_game_core wc_game_core_inst (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .main_cs       ( main_cs       ),
        .main_wr_n     ( main_wr_n     ),
        .main_addr     ( main_addr     ),
        .main_wdata    ( main_wdata    ),
        .main_rdata    ( main_rdata    ),
        .main_wait_req ( main_wait_req ),
        .sub_cs        ( sub_cs        ),
        .sub_wr_n      ( sub_wr_n      ),
        .sub_addr      ( sub_addr      ),
        .sub_wdata     ( sub_wdata     ),
        .sub_rdata     ( sub_rdata     ),
        .sub_wait_req  ( sub_wait_req  ),
        .cmd_wr        ( cmd_wr        ),
        .cmd_data      ( cmd_data      ),
        .cmd_wait      ( cmd_wait      ),
        .snd_cmd       ( snd_cmd       ),
        .snd_pending   ( snd_pending   ),
        .snd_ack       ( snd_ack       ),
        .scrx          ( scrx          ),
        .scry          ( scry          )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Checks failed");
            $fatal(1, "timeout: the run did not finish within %0d cycles", timeout_cycles);
        end
    end

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // region index from the memory map, -1 when the page is unmapped
    function automatic int page_region(input logic [page_w-1:0] page);
        for (int r = 0; r < region_count; r++) begin
            if (region_pages[r] == page) begin
                return r;
            end
        end
        return -1;
    endfunction

    function automatic logic [data_w-1:0] model_read(input logic [addr_w-1:0] addr);
        cpu_addr_u a;
        int        r;
        a.raw = addr;
        r = page_region(a.map.page);
        if (r < 0) begin
            return open_bus;
        end
        return ref_mem[r][a.map.ofs];
    endfunction

    function automatic void model_write(input bit is_main, input logic [addr_w-1:0] addr,
                                        input logic [data_w-1:0] data);
        cpu_addr_u a;
        int        r;
        a.raw = addr;
        r = page_region(a.map.page);
        if (r >= 0) begin
            ref_mem[r][a.map.ofs] = data;
        end else if (is_main) begin
            case (addr)
                scrx_lo_addr: exp_scrx[7:0] = data;
                scrx_hi_addr: exp_scrx[8]   = data[0];
                scry_addr:    exp_scry      = data;
                default:      ;
            endcase
        end
    endfunction

    // one access on either bus, cycles counts edges from cs rise to completion
    task automatic bus_access(input bit is_main, input bit wr, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata,
                              output int cycles);
        @(negedge clk);
        if (is_main) begin
            main_cs    = 1'b1;
            main_wr_n  = !wr;
            main_addr  = addr;
            main_wdata = wdata;
        end else begin
            sub_cs    = 1'b1;
            sub_wr_n  = !wr;
            sub_addr  = addr;
            sub_wdata = wdata;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (is_main ? main_wait_req : sub_wait_req);
        rdata = is_main ? main_rdata : sub_rdata;
        if (is_main) begin
            main_cs = 1'b0;
        end else begin
            sub_cs = 1'b0;
        end
        last_main = is_main;
    endtask

    task automatic ram_write(input bit is_main, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] data);
        logic [data_w-1:0] rd;
        int                cycles;
        bus_access(is_main, 1'b1, addr, data, rd, cycles);
        model_write(is_main, addr, data);
    endtask

    // uncontested read, always one wait edge
    task automatic ram_read_check(input bit is_main, input logic [addr_w-1:0] addr);
        logic [data_w-1:0] rd;
        int                cycles;
        bus_access(is_main, 1'b0, addr, 8'h00, rd, cycles);
        check_equal("read data", int'(model_read(addr)), int'(rd));
        check_equal("read wait cycles", 1, cycles);
    endtask

    // both masters raise cs together, the one not served last goes first
    task automatic contend(input bit wr, input logic [addr_w-1:0] m_addr,
                           input logic [data_w-1:0] m_wdata, input logic [addr_w-1:0] s_addr,
                           input logic [data_w-1:0] s_wdata, output logic [data_w-1:0] m_rdata,
                           output logic [data_w-1:0] s_rdata);
        int                m_cycles;
        int                s_cycles;
        bit                main_first;
        logic [data_w-1:0] m_rd;
        logic [data_w-1:0] s_rd;
        main_first = !last_main;
        fork
            bus_access(1'b1, wr, m_addr, m_wdata, m_rd, m_cycles);
            bus_access(1'b0, wr, s_addr, s_wdata, s_rd, s_cycles);
        join
        check_equal("main wait cycles", main_first ? 1 : 2, m_cycles);
        check_equal("sub wait cycles", main_first ? 2 : 1, s_cycles);
        m_rdata = m_rd;
        s_rdata = s_rd;
    endtask

    task automatic cmd_send(input logic [data_w-1:0] data, output int stalls);
        @(negedge clk);
        cmd_wr   = 1'b1;
        cmd_data = data;
        stalls   = 0;
        #settle_ns;
        while (cmd_wait) begin
            stalls++;
            @(negedge clk);
            #settle_ns;
        end
        // accepted at the coming rising edge
        @(negedge clk);
        cmd_wr = 1'b0;
    endtask

    task automatic cmd_receive(input logic [data_w-1:0] expected, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!snd_pending);
        check_equal("sound command", int'(expected), int'(snd_cmd));
        snd_ack = 1'b1;
        @(negedge clk);
        snd_ack = 1'b0;
        check_equal("pending after ack", 0, int'(snd_pending));
    endtask

    task automatic test_ram_rw();
        logic [addr_w-1:0] addr;
        test_name = "test_ram_rw";
        for (int r = 0; r < region_count; r++) begin
            for (int k = 0; k < 4; k++) begin
                addr = {region_pages[r], ofs_w'($random(seed))};
                ram_write(1'b1, addr, data_w'($random(seed)));
                written.push_back(addr);
            end
        end
        foreach (written[i]) begin
            ram_read_check(1'b1, written[i]);
        end
    endtask

    task automatic test_contention();
        logic [addr_w-1:0] m_addr;
        logic [addr_w-1:0] s_addr;
        logic [data_w-1:0] m_data;
        logic [data_w-1:0] s_data;
        logic [data_w-1:0] m_rd;
        logic [data_w-1:0] s_rd;
        test_name = "test_contention";
        for (int i = 0; i < 6; i++) begin
            // a solo access first so ties go to each master in turn
            ram_read_check((i % 2) == 1, written[i]);
            m_addr = {page_shram, ofs_w'($random(seed))};
            s_addr = {page_obj, ofs_w'($random(seed))};
            m_data = data_w'($random(seed));
            s_data = data_w'($random(seed));
            contend(1'b1, m_addr, m_data, s_addr, s_data, m_rd, s_rd);
            model_write(1'b1, m_addr, m_data);
            model_write(1'b0, s_addr, s_data);
            contend(1'b0, s_addr, 8'h00, m_addr, 8'h00, m_rd, s_rd);
            check_equal("main reads sub data", int'(model_read(s_addr)), int'(m_rd));
            check_equal("sub reads main data", int'(model_read(m_addr)), int'(s_rd));
        end
    endtask

    task automatic test_scroll_open();
        cpu_addr_u         known;
        logic [addr_w-1:0] hole;
        test_name = "test_scroll_open";
        ram_write(1'b1, scrx_lo_addr, data_w'($random(seed)));
        ram_write(1'b1, scrx_hi_addr, data_w'($random(seed)) | 8'h01);
        ram_write(1'b1, scry_addr, data_w'($random(seed)));
        check_equal("scrx", int'(exp_scrx), int'(scrx));
        check_equal("scry", int'(exp_scry), int'(scry));
        // sub CPU has no path to the scroll latches
        ram_write(1'b0, scrx_lo_addr, ~exp_scrx[7:0]);
        check_equal("scrx after sub write", int'(exp_scrx), int'(scrx));
        ram_read_check(1'b1, scrx_lo_addr);
        ram_read_check(1'b1, 16'h0123);
        ram_read_check(1'b0, 16'h4567);
        // same offset as a known location, but on an unmapped page
        known.raw = written[0];
        hole = {5'h02, known.map.ofs};
        ram_write(1'b1, hole, ~model_read(written[0]));
        ram_read_check(1'b1, written[0]);
        check_equal("scry at end", int'(exp_scry), int'(scry));
    endtask

    task automatic test_cmd_order();
        logic [data_w-1:0] cmd;
        int                stalls;
        int                waited;
        test_name = "test_cmd_order";
        for (int i = 0; i < 6; i++) begin
            cmd = data_w'($random(seed));
            cmd_send(cmd, stalls);
            check_equal("stalls on an empty queue", 0, stalls);
            cmd_receive(cmd, waited);
            // push edge, then pop edge into the latch
            check_equal("edges to pending", 1, waited);
        end
    endtask

    task automatic test_cmd_credit();
        logic [data_w-1:0] cmds [credits_total + 1];
        int                stalls;
        int                waited;
        test_name = "test_cmd_credit";
        foreach (cmds[i]) begin
            cmds[i] = data_w'($random(seed));
        end
        for (int i = 0; i < credits_total; i++) begin
            cmd_send(cmds[i], stalls);
            check_equal("stalls within credit", 0, stalls);
        end
        fork
            cmd_send(cmds[credits_total], stalls);
            begin
                repeat (4) @(negedge clk);
                #settle_ns;
                check_equal("cmd_wait with no credit", 1, int'(cmd_wait));
                cmd_receive(cmds[0], waited);
            end
        join
        check_equal("extra command stalled", 1, int'(stalls > 0));
        for (int i = 1; i <= credits_total; i++) begin
            cmd_receive(cmds[i], waited);
        end
    endtask

    initial begin
        region_pages[0] = page_shram;
        region_pages[1] = page_fix;
        region_pages[2] = page_scr;
        region_pages[3] = page_obj;
        region_pages[4] = page_pal;
        arst_n     = 1'b0;
        main_cs    = 1'b0;
        main_wr_n  = 1'b1;
        main_addr  = '0;
        main_wdata = '0;
        sub_cs     = 1'b0;
        sub_wr_n   = 1'b1;
        sub_addr   = '0;
        sub_wdata  = '0;
        cmd_wr     = 1'b0;
        cmd_data   = '0;
        snd_ack    = 1'b0;
        exp_scrx   = '0;
        exp_scry   = '0;
        last_main  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_name = "reset";
        check_equal("scrx", 0, int'(scrx));
        check_equal("scry", 0, int'(scry));
        check_equal("snd_cmd", 0, int'(snd_cmd));
        check_equal("snd_pending", 0, int'(snd_pending));
        check_equal("cmd_wait", 0, int'(cmd_wait));
        test_ram_rw();
        test_contention();
        test_scroll_open();
        test_cmd_order();
        test_cmd_credit();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/wc_pkg.sv
rtl/wc_shared_arb.sv
rtl/wc_shared_ram.sv
rtl/wc_cmd_producer.sv
rtl/wc_cmd_fifo.sv
rtl/wc_cmd_consumer.sv
rtl/wc_game_core.sv
sim/tb_wc_game_core.sv

// ==== Makefile ====
# Verilator build and run for the CPU core testbench

VERILATOR ?= verilator
TOP       ?= tb_wc_game_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
